/* Bender.yml */
package:
  name: fetch_frontend

sources:
  - include_dirs:
      - .
    files:
      - fetch_pkg.sv
      - bank_if.sv
      - imem_bank.sv
      - fetch_pc_gen.sv
      - fetch_align.sv
      - fetch_top.sv
      - target: test
        files:
          - tb_fetch_assertions.sv
          - tb_fetch.sv

/* all.f */
+incdir+.
fetch_pkg.sv
bank_if.sv
imem_bank.sv
fetch_pc_gen.sv
fetch_align.sv
fetch_top.sv
tb_fetch_assertions.sv
tb_fetch.sv

/* bank_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One halfword bank: read port plus write controls
interface bank_if
  import fetch_pkg::*;
();

  // Read side, row in, halfword out in the same cycle
  row_t   rd_row;
  hword_t rd_data;

  // Write side, sampled at the clock edge
  logic   wr_en;
  row_t   wr_row;
  hword_t wr_data;

  // PC generator drives addressing and write routing
  modport generator (
    output rd_row,
    output wr_en,
    output wr_row,
    output wr_data
  );

  // Memory bank itself
  modport bank (
    input  rd_row,
    input  wr_en,
    input  wr_row,
    input  wr_data,
    output rd_data
  );

  // Align block only looks at the read data
  modport drain (
    input rd_data
  );

endinterface

`default_nettype wire

/* fetch_align.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_macros.svh"

module fetch_align
  import fetch_pkg::*;
(
  input  wire logic  rst_ni,
  input  wire logic  stall_i,
  input  wire logic  redirect_i,
  // C extension enable
  input  wire logic  misa_c_i,
  input  wire addr_t pc_i,
  bank_if.drain      banks_i [`FETCH_NUM_BANKS],
  output logic       is_comp_o,
  output inst_t      inst_o,
  output exc_e       exc_o,
  output logic       valid_o
);

  // Halfwords of program memory in total
  localparam int unsigned NumHwords = `FETCH_NUM_BANKS * `FETCH_BANK_DEPTH;

  // System encodings
  localparam inst_t  InstEbreak  = 32'h0010_0073;
  localparam inst_t  InstEcall   = 32'h0000_0073;
  localparam hword_t InstCEbreak = 16'h9002;

  hword_t bank_data [`FETCH_NUM_BANKS];
  hword_t lo_hw;
  hword_t hi_hw;
  logic   is_comp;

  // Full halfword index and its successor, no truncation
  logic [`FETCH_XLEN-1:0] h_idx;
  logic [`FETCH_XLEN-1:0] h_next;

  logic misaligned;
  logic access_fault;
  logic illegal;
  logic breakpoint;
  logic ecall;

  // ==================================================
  // Halfword assembly
  // ==================================================

  for (genvar b = 0; b < `FETCH_NUM_BANKS; b++) begin : gen_drain
    assign bank_data[b] = banks_i[b].rd_data;
  end

  // pc bit 1 is the parity of h and names the bank of the low half
  assign lo_hw = bank_data[pc_i[1]];
  assign hi_hw = bank_data[!pc_i[1]];

  // Anything other than 2'b11 in the low bits is a 16-bit encoding
  assign is_comp   = (lo_hw[1:0] != 2'b11);
  assign is_comp_o = is_comp;

  // 16-bit instructions are shown zero-extended
  assign inst_o = is_comp ? {16'h0000, lo_hw} : {hi_hw, lo_hw};

  // ==================================================
  // Exception classification
  // ==================================================

  assign h_idx  = pc_i >> 1;
  assign h_next = h_idx + 1'b1;

  // Halfword alignment with C, word alignment without
  assign misaligned = misa_c_i ? pc_i[0] : (pc_i[1:0] != 2'b00);

  // Either half of the instruction past the end of memory
  assign access_fault = (h_idx >= NumHwords) || (!is_comp && (h_next >= NumHwords));

  // Compressed code without C, the zero halfword, reserved 32-bit opcodes
  assign illegal = (is_comp && !misa_c_i)
                || (is_comp && (lo_hw == 16'h0000))
                || (!is_comp && (lo_hw[4:2] == 3'b111));

  assign breakpoint = is_comp ? (lo_hw == InstCEbreak) : (inst_o == InstEbreak);
  assign ecall      = !is_comp && (inst_o == InstEcall);

  // Output is valid only outside reset, stall and redirect
  assign valid_o = rst_ni && !stall_i && !redirect_i;

  // Fixed priority, nothing reported without a valid fetch
  always_comb begin
    if (!valid_o) begin
      exc_o = EXC_NONE;
    end else if (misaligned) begin
      exc_o = EXC_MISALIGNED;
    end else if (access_fault) begin
      exc_o = EXC_ACCESS_FAULT;
    end else if (illegal) begin
      exc_o = EXC_ILLEGAL;
    end else if (breakpoint) begin
      exc_o = EXC_BREAKPOINT;
    end else if (ecall) begin
      exc_o = EXC_ECALL;
    end else begin
      exc_o = EXC_NONE;
    end
  end

endmodule

`default_nettype wire

/* fetch_macros.svh */
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// ==================================================
// Fetch front end parameters
// ==================================================

// Address and instruction width
`define FETCH_XLEN 32

// Halfword banks, the interleave needs exactly two
`define FETCH_NUM_BANKS 2

// Halfwords per bank, 2 x 64 halfwords give 256 bytes of program space
`define FETCH_BANK_DEPTH 64

// PC loaded while reset is asserted
`define FETCH_RESET_VECTOR 32'h0000_0000

`endif

/* fetch_pc_gen.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_macros.svh"

module fetch_pc_gen
  import fetch_pkg::*;
(
  input  wire logic   clk_i,
  input  wire logic   rst_ni,
  input  wire logic   stall_i,
  input  wire logic   redirect_i,
  input  wire addr_t  redirect_pc_i,
  // Length of the instruction at pc, from the align block
  input  wire logic   is_comp_i,
  input  wire logic   wr_en_i,
  input  wire hidx_t  wr_hidx_i,
  input  wire hword_t wr_data_i,
  output addr_t       pc_o,
  bank_if.generator   banks_o [`FETCH_NUM_BANKS]
);

  localparam int unsigned HidxW = $bits(hidx_t);

  addr_t pc_q;
  addr_t pc_incr;
  addr_t pc_next;

  // Halfword index of the low and high half of the fetch
  hidx_t h_lo;
  hidx_t h_hi;

  // ==================================================
  // PC register
  // ==================================================

  // Sequential step follows the reported length
  assign pc_incr = is_comp_i ? (pc_q + addr_t'(2)) : (pc_q + addr_t'(4));

  // Redirect beats stall, stall beats the step
  always_comb begin
    if (redirect_i) begin
      pc_next = redirect_pc_i;
    end else if (stall_i) begin
      pc_next = pc_q;
    end else begin
      pc_next = pc_incr;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pc_q <= addr_t'(`FETCH_RESET_VECTOR);
    end else begin
      pc_q <= pc_next;
    end
  end

  assign pc_o = pc_q;

  // ==================================================
  // Bank addressing and write routing
  // ==================================================

  // PC bit 0 plays no part in addressing
  assign h_lo = pc_q[HidxW:1];
  // Wraps at the end of memory, the align block flags that case
  assign h_hi = h_lo + hidx_t'(1);

  for (genvar b = 0; b < `FETCH_NUM_BANKS; b++) begin : gen_route
    // Each bank holds exactly one of h and h+1
    // Even h hits both banks at the same row, odd h steps bank 0 one row on
    assign banks_o[b].rd_row = (h_lo[0] == 1'(b)) ? h_lo[HidxW-1:1] : h_hi[HidxW-1:1];

    // Write goes to the bank named by the index parity
    assign banks_o[b].wr_en   = wr_en_i && (wr_hidx_i[0] == 1'(b));
    assign banks_o[b].wr_row  = wr_hidx_i[HidxW-1:1];
    assign banks_o[b].wr_data = wr_data_i;
  end

endmodule

`default_nettype wire

/* fetch_pkg.sv */
`default_nettype none
`include "fetch_macros.svh"

package fetch_pkg;

  // ==================================================
  // Vector types
  // ==================================================

  // Byte address
  typedef logic [`FETCH_XLEN-1:0] addr_t;

  // Assembled instruction word
  typedef logic [`FETCH_XLEN-1:0] inst_t;

  // One halfword of program memory
  typedef logic [15:0] hword_t;

  // Halfword index over the whole program memory
  typedef logic [$clog2(`FETCH_NUM_BANKS * `FETCH_BANK_DEPTH)-1:0] hidx_t;

  // Row inside one bank
  typedef logic [$clog2(`FETCH_BANK_DEPTH)-1:0] row_t;

  // ==================================================
  // Fetch exception code
  // ==================================================

  // Listed in decreasing priority after EXC_NONE
  typedef enum logic [2:0] {
    EXC_NONE         = 3'd0,
    EXC_MISALIGNED   = 3'd1,
    EXC_ACCESS_FAULT = 3'd2,
    EXC_ILLEGAL      = 3'd3,
    EXC_BREAKPOINT   = 3'd4,
    EXC_ECALL        = 3'd5
  } exc_e;

endpackage

`default_nettype wire

/* fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_macros.svh"

module fetch_top
  import fetch_pkg::*;
(
  input  wire logic   clk_i,
  input  wire logic   rst_ni,
  // Hold the PC
  input  wire logic   stall_i,
  // Jump strobe and its target
  input  wire logic   redirect_i,
  input  wire addr_t  redirect_pc_i,
  // C extension enable
  input  wire logic   misa_c_i,
  // Program memory write strobe
  input  wire logic   wr_en_i,
  input  wire hidx_t  wr_hidx_i,
  input  wire hword_t wr_data_i,
  output logic        valid_o,
  output addr_t       pc_o,
  output inst_t       inst_o,
  output logic        is_comp_o,
  output exc_e        exc_o
);

  // ==================================================
  // Bank buses
  // ==================================================

  bank_if bank_bus [`FETCH_NUM_BANKS] ();

  // ==================================================
  // PC generator
  // ==================================================

  // Step length comes back from the align block
  fetch_pc_gen i_pc_gen (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .stall_i       (stall_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .is_comp_i     (is_comp_o),
    .wr_en_i       (wr_en_i),
    .wr_hidx_i     (wr_hidx_i),
    .wr_data_i     (wr_data_i),
    .pc_o          (pc_o),
    .banks_o       (bank_bus)
  );

  // ==================================================
  // Halfword banks
  // ==================================================

  for (genvar b = 0; b < `FETCH_NUM_BANKS; b++) begin : gen_bank
    imem_bank i_bank (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .port_io (bank_bus[b])
    );
  end

  // ==================================================
  // Align and predecode
  // ==================================================

  fetch_align i_align (
    .rst_ni     (rst_ni),
    .stall_i    (stall_i),
    .redirect_i (redirect_i),
    .misa_c_i   (misa_c_i),
    .pc_i       (pc_o),
    .banks_i    (bank_bus),
    .is_comp_o  (is_comp_o),
    .inst_o     (inst_o),
    .exc_o      (exc_o),
    .valid_o    (valid_o)
  );

endmodule

`default_nettype wire

/* imem_bank.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_macros.svh"

module imem_bank
  import fetch_pkg::*;
(
  input  wire logic clk_i,
  input  wire logic rst_ni,
  bank_if.bank      port_io
);

  // ==================================================
  // Halfword storage
  // ==================================================

  hword_t mem [`FETCH_BANK_DEPTH];

  // Write lands at the edge, readable from the next cycle on
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      // Walk every row back to zero
      for (int row = 0; row < `FETCH_BANK_DEPTH; row++) begin
        mem[row] <= '0;
      end
    end else if (port_io.wr_en) begin
      mem[port_io.wr_row] <= port_io.wr_data;
    end
  end

  // ==================================================
  // Read port
  // ==================================================

  // Combinational read so fetch completes in one cycle
  assign port_io.rd_data = mem[port_io.rd_row];

endmodule

`default_nettype wire

/* tb_fetch.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fetch_macros.svh"

module tb_fetch
  import fetch_pkg::*;
();

  localparam int NumHw = `FETCH_NUM_BANKS * `FETCH_BANK_DEPTH;
  // Cycle budget of each test
  localparam int CycReset = 4;
  localparam int CycLoad  = NumHw + 61;
  localparam int CycMixed = NumHw + 55;
  localparam int CycJump  = 200;
  localparam int CycExc   = 10 + 2 * 16;
  localparam int CycWrite = 8 * 4;
  // Timeout at twice the sum of all budgets
  localparam int CycLimit = 2 * (CycReset + CycLoad + CycMixed + CycJump + CycExc + CycWrite);
  // C extension enable for exception case i sits in bit i
  localparam logic [15:0] ExcC = 16'h55B9;

  // DUT inputs
  logic   clk_i;
  logic   rst_ni;
  logic   stall_i;
  logic   redirect_i;
  addr_t  redirect_pc_i;
  logic   misa_c_i;
  logic   wr_en_i;
  hidx_t  wr_hidx_i;
  hword_t wr_data_i;

  // DUT outputs
  logic   valid_o;
  addr_t  pc_o;
  inst_t  inst_o;
  logic   is_comp_o;
  exc_e   exc_o;

  // Reference model state
  hword_t mem_m [NumHw];
  addr_t pc_m;
  // Jump targets of the exception cases
  addr_t exc_tgt [16];
  // Levels applied at the next drive
  logic c_next;
  logic rst_next;
  addr_t tgt;
  int unsigned cycles = 0;

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  fetch_top i_dut (
    .clk_i (clk_i), .rst_ni (rst_ni), .stall_i (stall_i), .redirect_i (redirect_i),
    .redirect_pc_i (redirect_pc_i), .misa_c_i (misa_c_i), .wr_en_i (wr_en_i),
    .wr_hidx_i (wr_hidx_i), .wr_data_i (wr_data_i), .valid_o (valid_o), .pc_o (pc_o),
    .inst_o (inst_o), .is_comp_o (is_comp_o), .exc_o (exc_o)
  );

  // ==================================================
  // Reference model
  // ==================================================

  // Memory decodes only the low index bits
  function automatic hword_t hw_at(input addr_t h);
    return mem_m[h % NumHw];
  endfunction

  // Exception rules in priority order
  function automatic exc_e exc_of(input addr_t pc, input logic c);
    addr_t h;
    hword_t lo;
    inst_t word;
    logic comp;
    h = pc >> 1;
    lo = hw_at(h);
    comp = (lo[1:0] != 2'b11);
    word = {hw_at(h + 1), lo};
    if (c ? pc[0] : (pc[1:0] != 2'b00)) begin
      return EXC_MISALIGNED;
    end else if (h >= NumHw || (!comp && h + 1 >= NumHw)) begin
      return EXC_ACCESS_FAULT;
    end else if ((comp && (!c || lo == 16'h0000)) || (!comp && word[4:2] == 3'b111)) begin
      return EXC_ILLEGAL;
    end else if (comp ? (lo == 16'h9002) : (word == 32'h0010_0073)) begin
      return EXC_BREAKPOINT;
    end else if (!comp && word == 32'h0000_0073) begin
      return EXC_ECALL;
    end
    return EXC_NONE;
  endfunction

  // Update at a rising edge from the inputs in place before it
  task automatic model_edge();
    hword_t lo;
    // Step length comes from the memory before any write at this edge
    lo = hw_at(pc_m >> 1);
    if (!rst_ni) begin
      pc_m = `FETCH_RESET_VECTOR;
      for (int i = 0; i < NumHw; i++) begin
        mem_m[i] = '0;
      end
    end else begin
      if (redirect_i) begin
        pc_m = redirect_pc_i;
      end else if (!stall_i) begin
        pc_m = pc_m + ((lo[1:0] != 2'b11) ? 2 : 4);
      end
      if (wr_en_i) begin
        mem_m[wr_hidx_i] = wr_data_i;
      end
    end
  endtask

  // ==================================================
  // Compare tasks
  // ==================================================

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp)
      fail_run($sformatf("** Error: %s expected 0x%h actual 0x%h", name, exp, act));
  endtask

  task automatic check_inst(input string name, input inst_t exp, input inst_t act);
    if (act !== exp)
      fail_run($sformatf("** Error: %s expected 0x%h actual 0x%h", name, exp, act));
  endtask

  task automatic check_exc(input string name, input exc_e exp, input exc_e act);
    if (act !== exp)
      fail_run($sformatf("** Error: %s expected 0x%h actual 0x%h", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
      fail_run($sformatf("** Error: %s expected 0x%h actual 0x%h", name, exp, act));
  endtask

  // All five outputs against the model
  task automatic check_outputs();
    logic valid;
    hword_t lo;
    logic comp;
    valid = rst_ni && !stall_i && !redirect_i;
    lo = hw_at(pc_m >> 1);
    comp = (lo[1:0] != 2'b11);
    check_bit("valid_o", valid, valid_o);
    check_addr("pc_o", pc_m, pc_o);
    check_bit("is_comp_o", comp, is_comp_o);
    check_inst("inst_o", comp ? {16'h0000, lo} : {hw_at((pc_m >> 1) + 1), lo}, inst_o);
    check_exc("exc_o", valid ? exc_of(pc_m, misa_c_i) : EXC_NONE, exc_o);
  endtask

  // ==================================================
  // Stimulus helpers
  // ==================================================

  // Drive at the rising edge and check at the falling edge
  task automatic tick(input logic st, input logic rd, input addr_t target,
                      input logic we, input hidx_t wi, input hword_t wd);
    @(posedge clk_i);
    model_edge();
    rst_ni <= rst_next;
    misa_c_i <= c_next;
    stall_i <= st;
    redirect_i <= rd;
    redirect_pc_i <= target;
    wr_en_i <= we;
    wr_hidx_i <= wi;
    wr_data_i <= wd;
    @(negedge clk_i);
    check_outputs();
    // Bound properties fire at the rising edge, their count is settled here
    if (i_dut.i_assertions.fail_count != 0)
      fail_run("A bound assertion on fetch_top failed");
  endtask

  task automatic run(input logic st, input int n);
    repeat (n) tick(st, 1'b0, '0, 1'b0, '0, '0);
  endtask

  task automatic jump(input addr_t target);
    tick(1'b0, 1'b1, target, 1'b0, '0, '0);
  endtask

  task automatic write_hw(input hidx_t wi, input hword_t wd, input logic st);
    tick(st, 1'b0, '0, 1'b1, wi, wd);
  endtask

  // Low half of a 32-bit instruction
  // Bit 4 clear keeps it off the reserved opcodes
  function automatic hword_t rand_wide_lo();
    hword_t r;
    r = hword_t'($urandom);
    return {r[15:5], 1'b0, r[3:2], 2'b11};
  endfunction

  // Non-zero 16-bit encoding
  function automatic hword_t rand_comp();
    hword_t r;
    r = hword_t'($urandom);
    return {r[15:3], 1'b1, r[1], 1'b0};
  endfunction

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CycLimit)
      fail_run($sformatf("Timeout: run went past %0d cycles without finishing", CycLimit));
  end

  // ==================================================
  // Test sequence
  // ==================================================

  initial begin
    rst_ni = 1'b0;
    stall_i = 1'b0;
    redirect_i = 1'b0;
    redirect_pc_i = '0;
    misa_c_i = 1'b0;
    wr_en_i = 1'b0;
    wr_hidx_i = '0;
    wr_data_i = '0;
    c_next = 1'b0;
    rst_next = 1'b0;
    pc_m = `FETCH_RESET_VECTOR;
    void'($urandom(31817));
    // Release lands with the fourth reset edge
    run(1'b0, CycReset - 1);
    rst_next = 1'b1;
    run(1'b0, 1);

    // Load 32-bit code with C off and run straight through it
    for (int w = 0; w < NumHw / 2; w++) begin
      write_hw(hidx_t'(2 * w), rand_wide_lo(), 1'b1);
      write_hw(hidx_t'(2 * w + 1), hword_t'($urandom), 1'b1);
    end
    jump('0);
    run(1'b0, 60);

    // Mixed lengths with C on
    c_next = 1'b1;
    for (int h = 0; h < NumHw; h++) begin
      write_hw(hidx_t'(h), ($urandom % 2) ? rand_comp() : rand_wide_lo(), 1'b1);
    end
    // 32-bit word across the row boundary at odd index 7
    write_hw(hidx_t'(7), rand_wide_lo(), 1'b1);
    write_hw(hidx_t'(8), hword_t'($urandom), 1'b1);
    jump(addr_t'(14));
    run(1'b0, 1);
    jump('0);
    run(1'b0, 50);

    // Random stall and redirect
    for (int i = 0; i < CycJump; i++) begin
      tgt = addr_t'(($urandom % NumHw) * 2);
      tick($urandom % 4 == 0, $urandom % 5 == 0, tgt, 1'b0, '0, '0);
    end

    // Exception cases
    // Zero halfword, reserved word, c.li, ebreak, c.ebreak and ecall
    write_hw(hidx_t'(10), 16'h0000, 1'b1);
    write_hw(hidx_t'(12), 16'h001F, 1'b1);
    write_hw(hidx_t'(13), 16'h0000, 1'b1);
    write_hw(hidx_t'(14), 16'h4501, 1'b1);
    write_hw(hidx_t'(16), 16'h0073, 1'b1);
    write_hw(hidx_t'(17), 16'h0010, 1'b1);
    write_hw(hidx_t'(18), 16'h9002, 1'b1);
    write_hw(hidx_t'(20), 16'h0073, 1'b1);
    write_hw(hidx_t'(21), 16'h0000, 1'b1);
    // 32-bit low half in the last halfword
    write_hw(hidx_t'(127), 16'h0013, 1'b1);
    exc_tgt = '{32'h29, 32'h29, 32'h2A, 32'h2A, 32'hFE, 32'h100, 32'h1F0, 32'h14,
                32'h18, 32'h1C, 32'h1C, 32'h20, 32'h24, 32'h28, 32'hFC, 32'h101};
    for (int i = 0; i < 16; i++) begin
      c_next = ExcC[i];
      jump(exc_tgt[i]);
      run(1'b0, 1);
    end

    // Overwrite the halfwords under a stalled pc
    c_next = 1'b1;
    for (int i = 0; i < 8; i++) begin
      tgt = addr_t'(($urandom % (NumHw - 2)) * 2);
      jump(tgt);
      write_hw(hidx_t'(tgt >> 1), ($urandom % 2) ? rand_comp() : rand_wide_lo(), 1'b1);
      write_hw(hidx_t'((tgt >> 1) + 1), hword_t'($urandom), 1'b1);
      run(1'b0, 1);
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* tb_fetch_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_assertions
  import fetch_pkg::*;
(
  input wire logic  clk_i,
  input wire logic  rst_ni,
  input wire logic  stall_i,
  input wire logic  redirect_i,
  input wire logic  valid_o,
  input wire addr_t pc_o,
  input wire exc_e  exc_o
);

  // Running count of property failures
  int unsigned fail_count = 0;

  // ==================================================
  // Output and PC properties
  // ==================================================

  // Nothing is fetched while reset is held
  valid_low_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !valid_o)
    else begin
      $error("valid_o high during reset");
      fail_count++;
    end

  // Exception code is only meaningful with a valid fetch
  exc_none_when_idle: assert property (@(posedge clk_i) !valid_o |-> exc_o == EXC_NONE)
    else begin
      $error("exc_o set without valid_o");
      fail_count++;
    end

  // A stalled edge leaves the PC where it was
  pc_holds_on_stall: assert property (@(posedge clk_i)
    rst_ni && stall_i && !redirect_i |=> $stable(pc_o))
    else begin
      $error("pc_o moved across a stalled edge");
      fail_count++;
    end

endmodule

bind fetch_top tb_fetch_assertions i_assertions (.*);

`default_nettype wire
